// File: Makefile
# Verilator build, run and lint for the cache

VERILATOR  ?= verilator
TOP        := tb_cache_top
RTL_TOP    := cache_top
FILELIST   := files.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass or fail comes from the log, not from the exit status
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+include
src/cache_store_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_array.sv
src/cache_datapath.sv
src/cache_ctrl.sv
src/cache_top.sv
verif/tb_clkgen.sv
verif/mem_model.sv
verif/tb_cache_top.sv

// File: include/cache_defines.svh
// cache geometry macros

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// data word and line shape
`define CACHE_WORD_W      32
`define CACHE_WORDS       4

// number of direct-mapped lines
`define CACHE_LINES       8

// processor word address split into tag, index and offset
`define CACHE_ADDR_W      30
`define CACHE_OFFSET_W    2
`define CACHE_INDEX_W     3
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

// line address toward the slow memory
`define CACHE_MEM_ADDR_W  (`CACHE_ADDR_W - `CACHE_OFFSET_W)

`endif

// File: src/cache_array.sv
// indexed line storage

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_array
	import cache_store_pkg::*;
#(
	parameter type entry_t = line_t,
	parameter int  DEPTH   = `CACHE_LINES
) (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire index_t rd_index_i,
	output entry_t      rd_entry_o,
	input  wire logic   we_i,
	input  wire index_t wr_index_i,
	input  wire entry_t wr_entry_i
);

	entry_t mem_q [DEPTH];

	// combinational read
	assign rd_entry_o = mem_q[rd_index_i];

	// all entries cleared, so every line starts invalid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem_q[i] <= '0;
			end
		end else if (we_i) begin
			mem_q[wr_index_i] <= wr_entry_i;
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	// a write must target a known line
	a_wr_index_known: assert property (@(posedge clk) disable iff (!rst_n)
		we_i |-> !$isunknown(wr_index_i));

endmodule

`default_nettype wire

// File: src/cache_ctrl.sv
// cache controller

`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
	import cache_store_pkg::*;
	import cache_ctrl_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       proc_read_i,
	input  wire logic       proc_write_i,
	input  wire tag_t       proc_tag_i,
	input  wire index_t     proc_index_i,
	input  wire tag_entry_t entry_i,
	input  wire logic       mem_ready_i,
	output logic            proc_stall_o,
	output logic            mem_read_o,
	output logic            mem_write_o,
	output mem_addr_t       mem_addr_o,
	output logic            tag_we_o,
	output tag_entry_t      entry_o,
	output logic            data_we_o,
	output logic            fill_sel_o
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	logic        req;
	logic        hit;
	logic        victim_dirty;
	logic        mem_read_q;
	logic        mem_write_q;
	mem_addr_t   mem_addr_q;

	assign req          = proc_read_i | proc_write_i;
	assign hit          = entry_i.valid && (entry_i.tag == proc_tag_i);
	assign victim_dirty = entry_i.valid && entry_i.dirty;

	// hits complete in the request cycle
	assign proc_stall_o = (state_q != S_COMPARE) || (req && !hit);

	// ----------------------------------------------------------------------
	// miss FSM
	// ----------------------------------------------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_COMPARE: begin
				if (req && !hit) begin
					state_d = victim_dirty ? S_WRITE_BACK : S_REFILL;
				end
			end
			// back to compare, which then sees a clean miss
			S_WRITE_BACK: begin
				if (mem_ready_i) begin
					state_d = S_COMPARE;
				end
			end
			S_REFILL: begin
				if (mem_ready_i) begin
					state_d = S_REFILL_DONE;
				end
			end
			default: begin
				state_d = S_COMPARE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= S_COMPARE;
		end else begin
			state_q <= state_d;
		end
	end

	// ----------------------------------------------------------------------
	// tag and data store updates
	// ----------------------------------------------------------------------

	always_comb begin
		tag_we_o   = 1'b0;
		data_we_o  = 1'b0;
		fill_sel_o = 1'b0;
		entry_o    = entry_i;
		case (state_q)
			S_COMPARE: begin
				if (proc_write_i && hit) begin
					tag_we_o      = 1'b1;
					data_we_o     = 1'b1;
					entry_o.dirty = 1'b1;
				end
			end
			// victim now matches memory
			S_WRITE_BACK: begin
				if (mem_ready_i) begin
					tag_we_o      = 1'b1;
					entry_o.dirty = 1'b0;
				end
			end
			S_REFILL: begin
				fill_sel_o = 1'b1;
				if (mem_ready_i) begin
					tag_we_o      = 1'b1;
					data_we_o     = 1'b1;
					entry_o.valid = 1'b1;
					entry_o.dirty = 1'b0;
					entry_o.tag   = proc_tag_i;
				end
			end
			default: begin
				fill_sel_o = 1'b0;
			end
		endcase
	end

	// ----------------------------------------------------------------------
	// memory request, held until ready
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_read_q  <= 1'b0;
			mem_write_q <= 1'b0;
			mem_addr_q  <= '0;
		end else begin
			case (state_q)
				S_COMPARE: begin
					if (req && !hit && victim_dirty) begin
						mem_write_q <= 1'b1;
						mem_addr_q  <= {entry_i.tag, proc_index_i};
					end else if (req && !hit) begin
						mem_read_q <= 1'b1;
						mem_addr_q <= {proc_tag_i, proc_index_i};
					end
				end
				S_WRITE_BACK: begin
					if (mem_ready_i) begin
						mem_write_q <= 1'b0;
					end
				end
				S_REFILL: begin
					if (mem_ready_i) begin
						mem_read_q <= 1'b0;
					end
				end
				default: begin
					mem_read_q  <= 1'b0;
					mem_write_q <= 1'b0;
				end
			endcase
		end
	end

	assign mem_read_o  = mem_read_q;
	assign mem_write_o = mem_write_q;
	assign mem_addr_o  = mem_addr_q;

	// one memory operation at a time
	a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read_o && mem_write_o));

	// request and address stay put until the memory answers
	a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_read_o || mem_write_o) && !mem_ready_i |=>
			$stable(mem_read_o) && $stable(mem_write_o) && $stable(mem_addr_o));

endmodule

`default_nettype wire

// File: src/cache_ctrl_pkg.sv
// cache controller types

`default_nettype none

`include "cache_defines.svh"

package cache_ctrl_pkg;

	// miss handling states
	typedef enum logic [1:0] {
		S_COMPARE     = 2'd0,
		S_WRITE_BACK  = 2'd1,
		S_REFILL      = 2'd2,
		S_REFILL_DONE = 2'd3
	} ctrl_state_t;

	// line address, tag above index
	typedef logic [`CACHE_MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

// File: src/cache_datapath.sv
// cache data path

`timescale 1ns/1ps
`default_nettype none

module cache_datapath
	import cache_store_pkg::*;
(
	input  wire offset_t proc_offset_i,
	input  wire word_t   proc_wdata_i,
	input  wire line_t   line_i,
	input  wire line_t   mem_rdata_i,
	input  wire logic    fill_sel_i,
	output line_t        line_o,
	output word_t        rdata_o,
	output line_t        mem_wdata_o
);

	line_t merged_line;
	line_t fill_line;

	// ----------------------------------------------------------------------
	// read side
	// ----------------------------------------------------------------------

	// addressed word of the stored line
	assign rdata_o = line_i[proc_offset_i];

	// ----------------------------------------------------------------------
	// write side
	// ----------------------------------------------------------------------

	// stored line with the processor word dropped in
	always_comb begin
		merged_line = line_i;
		merged_line[proc_offset_i] = proc_wdata_i;
	end

	// unpack the memory line word by word
	always_comb begin
		for (int k = 0; k < $bits(line_t) / $bits(word_t); k++) begin
			fill_line[k] = mem_rdata_i[k];
		end
	end

	// refill data wins while a line is being brought in
	assign line_o = fill_sel_i ? fill_line : merged_line;

	// ----------------------------------------------------------------------
	// write-back side
	// ----------------------------------------------------------------------

	// victim line packed for the memory bus, word 0 lowest
	always_comb begin
		for (int k = 0; k < $bits(line_t) / $bits(word_t); k++) begin
			mem_wdata_o[k] = line_i[k];
		end
	end

endmodule

`default_nettype wire

// File: src/cache_store_pkg.sv
// cache storage types

`default_nettype none

`include "cache_defines.svh"

package cache_store_pkg;

	// ----------------------------------------------------------------------
	// data payload
	// ----------------------------------------------------------------------

	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// word k sits in slice k, word 0 in the low bits
	typedef word_t [`CACHE_WORDS-1:0] line_t;

	// ----------------------------------------------------------------------
	// address fields and tag store entry
	// ----------------------------------------------------------------------

	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
	typedef logic [`CACHE_INDEX_W-1:0]  index_t;
	typedef logic [`CACHE_TAG_W-1:0]    tag_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} tag_entry_t;

endpackage

`default_nettype wire

// File: src/cache_top.sv
// direct-mapped write-back cache

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_top
	import cache_store_pkg::*;
	import cache_ctrl_pkg::*;
(
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     proc_read_i,
	input  wire logic                     proc_write_i,
	input  wire logic [`CACHE_ADDR_W-1:0] proc_addr_i,
	input  wire word_t                    proc_wdata_i,
	output logic                          proc_stall_o,
	output word_t                         proc_rdata_o,
	output logic                          mem_read_o,
	output logic                          mem_write_o,
	output mem_addr_t                     mem_addr_o,
	output line_t                         mem_wdata_o,
	input  wire line_t                    mem_rdata_i,
	input  wire logic                     mem_ready_i
);

	offset_t    proc_offset;
	index_t     proc_index;
	tag_t       proc_tag;
	tag_entry_t tag_rd;
	tag_entry_t tag_wr;
	logic       tag_we;
	line_t      line_rd;
	line_t      line_wr;
	logic       data_we;
	logic       fill_sel;

	// word address fields
	assign proc_offset = proc_addr_i[`CACHE_OFFSET_W-1:0];
	assign proc_index  = proc_addr_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign proc_tag    = proc_addr_i[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

	// ----------------------------------------------------------------------
	// control
	// ----------------------------------------------------------------------

	cache_ctrl u_cache_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.proc_read_i  (proc_read_i),
		.proc_write_i (proc_write_i),
		.proc_tag_i   (proc_tag),
		.proc_index_i (proc_index),
		.entry_i      (tag_rd),
		.mem_ready_i  (mem_ready_i),
		.proc_stall_o (proc_stall_o),
		.mem_read_o   (mem_read_o),
		.mem_write_o  (mem_write_o),
		.mem_addr_o   (mem_addr_o),
		.tag_we_o     (tag_we),
		.entry_o      (tag_wr),
		.data_we_o    (data_we),
		.fill_sel_o   (fill_sel)
	);

	cache_datapath u_cache_datapath (
		.proc_offset_i (proc_offset),
		.proc_wdata_i  (proc_wdata_i),
		.line_i        (line_rd),
		.mem_rdata_i   (mem_rdata_i),
		.fill_sel_i    (fill_sel),
		.line_o        (line_wr),
		.rdata_o       (proc_rdata_o),
		.mem_wdata_o   (mem_wdata_o)
	);

	// ----------------------------------------------------------------------
	// tag and data stores
	// ----------------------------------------------------------------------

	cache_array #(.entry_t(tag_entry_t)) u_tag_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_index_i (proc_index),
		.rd_entry_o (tag_rd),
		.we_i       (tag_we),
		.wr_index_i (proc_index),
		.wr_entry_i (tag_wr)
	);

	cache_array #(.entry_t(line_t)) u_data_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_index_i (proc_index),
		.rd_entry_o (line_rd),
		.we_i       (data_we),
		.wr_index_i (proc_index),
		.wr_entry_i (line_wr)
	);

endmodule

`default_nettype wire

// File: verif/mem_model.sv
// slow line memory model

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module mem_model
	import cache_store_pkg::*;
	import cache_ctrl_pkg::*;
#(
	parameter int DELAY = 5
) (
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire logic      mem_read_i,
	input  wire logic      mem_write_i,
	input  wire mem_addr_t mem_addr_i,
	input  wire line_t     mem_wdata_i,
	output line_t          mem_rdata_o,
	output logic           mem_ready_o
);

	localparam int LINES = 256;

	line_t      lines [LINES];
	int         wait_cnt;
	logic [7:0] line_sel;

	assign line_sel = mem_addr_i[7:0];

	// ----------------------------------------------------------------------
	// request handling, one ready pulse DELAY cycles after the request
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// word k of line a starts as a*4+k with the upper half marked
			for (int a = 0; a < LINES; a++) begin
				for (int k = 0; k < `CACHE_WORDS; k++) begin
					lines[a][k] <= word_t'(a * 4 + k) ^ 32'hA5A5_0000;
				end
			end
			wait_cnt    <= 0;
			mem_ready_o <= 1'b0;
			mem_rdata_o <= '0;
		end else begin
			mem_ready_o <= 1'b0;
			// the request is still seen during the ready cycle
			if ((mem_read_i || mem_write_i) && !mem_ready_o) begin
				if (wait_cnt == DELAY - 1) begin
					wait_cnt    <= 0;
					mem_ready_o <= 1'b1;
					if (mem_write_i) begin
						lines[line_sel] <= mem_wdata_i;
					end else begin
						mem_rdata_o <= lines[line_sel];
					end
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_cache_top.sv
// cache testbench

`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module tb_cache_top
	import cache_store_pkg::*;
	import cache_ctrl_pkg::*;
();

	localparam int TIMEOUT = 200;

	// line 20 and line 36 share index 4
	localparam logic [`CACHE_ADDR_W-1:0] LINE_A = 30'h50;
	localparam logic [`CACHE_ADDR_W-1:0] LINE_B = 30'h90;

	logic                     clk;
	logic                     rst_n;
	logic                     proc_read_i;
	logic                     proc_write_i;
	logic [`CACHE_ADDR_W-1:0] proc_addr_i;
	word_t                    proc_wdata_i;
	logic                     proc_stall_o;
	word_t                    proc_rdata_o;
	logic                     mem_read_o;
	logic                     mem_write_o;
	mem_addr_t                mem_addr_o;
	line_t                    mem_wdata_o;
	line_t                    mem_rdata_i;
	logic                     mem_ready_i;

	int          check_count;
	int          error_count;
	logic        aborted;
	logic [31:0] lfsr_state;
	word_t       shadow_mem [int unsigned];

	// memory activity seen during the last access
	int          stall_cycles;
	logic        saw_read;
	logic        saw_write;
	logic        write_first;
	mem_addr_t   wb_addr;
	line_t       wb_line;

	tb_clkgen u_tb_clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	cache_top u_cache_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.proc_read_i  (proc_read_i),
		.proc_write_i (proc_write_i),
		.proc_addr_i  (proc_addr_i),
		.proc_wdata_i (proc_wdata_i),
		.proc_stall_o (proc_stall_o),
		.proc_rdata_o (proc_rdata_o),
		.mem_read_o   (mem_read_o),
		.mem_write_o  (mem_write_o),
		.mem_addr_o   (mem_addr_o),
		.mem_wdata_o  (mem_wdata_o),
		.mem_rdata_i  (mem_rdata_i),
		.mem_ready_i  (mem_ready_i)
	);

	mem_model u_mem_model (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_read_i  (mem_read_o),
		.mem_write_i (mem_write_o),
		.mem_addr_i  (mem_addr_o),
		.mem_wdata_i (mem_wdata_o),
		.mem_rdata_o (mem_rdata_i),
		.mem_ready_o (mem_ready_i)
	);

	// ----------------------------------------------------------------------
	// reference values and random source
	// ----------------------------------------------------------------------

	// word k of line A starts as A*4+k, upper half marked
	function automatic word_t memory_rule_word(input logic [`CACHE_ADDR_W-1:0] addr);
		logic [31:0] line_addr;
		logic [31:0] k;
		line_addr = 32'(addr[`CACHE_ADDR_W-1:2]);
		k = 32'(addr[1:0]);
		return (line_addr * 32'd4 + k) ^ 32'hA5A5_0000;
	endfunction

	function automatic word_t shadow_word(input logic [`CACHE_ADDR_W-1:0] addr);
		if (shadow_mem.exists(32'(addr))) begin
			return shadow_mem[32'(addr)];
		end
		return memory_rule_word(addr);
	endfunction

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	// ----------------------------------------------------------------------
	// checking and processor access
	// ----------------------------------------------------------------------

	task automatic compare_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (aborted) begin
			return;
		end
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic watch_memory();
		if (mem_write_o && !saw_write) begin
			saw_write = 1'b1;
			write_first = !saw_read;
			wb_addr = mem_addr_o;
			wb_line = mem_wdata_o;
		end
		if (mem_read_o) begin
			saw_read = 1'b1;
		end
	endtask

	// request held until stall falls, sampled on the falling edge
	task automatic cpu_access(input logic is_write, input logic [`CACHE_ADDR_W-1:0] addr,
			input word_t wdata, output word_t rdata);
		int cycles;
		rdata = '0;
		cycles = 0;
		stall_cycles = 0;
		saw_read = 1'b0;
		saw_write = 1'b0;
		write_first = 1'b0;
		wb_addr = '0;
		wb_line = '0;
		if (aborted) begin
			return;
		end
		@(posedge clk);
		proc_read_i  <= !is_write;
		proc_write_i <= is_write;
		proc_addr_i  <= addr;
		proc_wdata_i <= wdata;
		@(negedge clk);
		watch_memory();
		while (proc_stall_o && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			watch_memory();
		end
		if (proc_stall_o) begin
			$display("request to word address %h did not complete within %0d cycles",
				addr, TIMEOUT);
			error_count++;
			aborted = 1'b1;
		end else begin
			rdata = proc_rdata_o;
			if (is_write) begin
				shadow_mem[32'(addr)] = wdata;
			end
		end
		stall_cycles = cycles;
		@(posedge clk);
		proc_read_i  <= 1'b0;
		proc_write_i <= 1'b0;
	endtask

	task automatic print_test_line(input string name, input int errs_before);
		if (error_count == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, error_count - errs_before);
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------

	task automatic idle_after_reset();
		int    errs_before;
		logic  busy;
		word_t rdata;
		errs_before = error_count;
		busy = 1'b0;
		repeat (20) begin
			@(negedge clk);
			busy = busy | mem_read_o | mem_write_o | proc_stall_o;
		end
		compare_value("idle outputs after reset", 32'(busy), 32'd0);
		// one read per index, all lines start invalid
		for (int i = 0; i < `CACHE_LINES; i++) begin
			cpu_access(1'b0, 30'(i * 4), '0, rdata);
			compare_value("first read raises mem_read", 32'(saw_read), 32'd1);
			compare_value("first read data", rdata, shadow_word(30'(i * 4)));
		end
		print_test_line("reset state", errs_before);
	endtask

	task automatic read_miss_then_hit();
		int    errs_before;
		word_t rdata;
		errs_before = error_count;
		cpu_access(1'b0, LINE_A + 30'd1, '0, rdata);
		compare_value("miss stalls", 32'(stall_cycles > 0), 32'd1);
		compare_value("miss raises mem_read", 32'(saw_read), 32'd1);
		compare_value("miss read data", rdata, shadow_word(LINE_A + 30'd1));
		cpu_access(1'b0, LINE_A + 30'd3, '0, rdata);
		compare_value("hit stall cycles", 32'(stall_cycles), 32'd0);
		compare_value("hit memory traffic", 32'(saw_read | saw_write), 32'd0);
		compare_value("hit read data", rdata, shadow_word(LINE_A + 30'd3));
		print_test_line("read miss then hit", errs_before);
	endtask

	task automatic write_hit_readback();
		int    errs_before;
		word_t rdata;
		errs_before = error_count;
		cpu_access(1'b1, LINE_A + 30'd2, 32'h1234_5678, rdata);
		compare_value("write hit stall cycles", 32'(stall_cycles), 32'd0);
		compare_value("write hit memory traffic", 32'(saw_read | saw_write), 32'd0);
		for (int k = 0; k < `CACHE_WORDS; k++) begin
			cpu_access(1'b0, LINE_A + 30'(k), '0, rdata);
			compare_value("readback stall cycles", 32'(stall_cycles), 32'd0);
			compare_value("readback memory traffic", 32'(saw_read | saw_write), 32'd0);
			compare_value("readback data", rdata, shadow_word(LINE_A + 30'(k)));
		end
		print_test_line("write hit and read back", errs_before);
	endtask

	task automatic dirty_eviction();
		int    errs_before;
		word_t rdata;
		errs_before = error_count;
		cpu_access(1'b1, LINE_A, 32'hFACE_B00C, rdata);
		cpu_access(1'b0, LINE_B + 30'd1, '0, rdata);
		compare_value("victim written back", 32'(saw_write), 32'd1);
		compare_value("write-back before refill", 32'(write_first), 32'd1);
		compare_value("write-back address", 32'(wb_addr), 32'(LINE_A[`CACHE_ADDR_W-1:2]));
		for (int k = 0; k < `CACHE_WORDS; k++) begin
			compare_value("write-back word", wb_line[k], shadow_word(LINE_A + 30'(k)));
		end
		compare_value("refill after write-back", 32'(saw_read), 32'd1);
		compare_value("new line read data", rdata, shadow_word(LINE_B + 30'd1));
		// the new line is clean, so only a refill
		cpu_access(1'b0, LINE_A, '0, rdata);
		compare_value("clean victim not written", 32'(saw_write), 32'd0);
		compare_value("reread written word", rdata, 32'hFACE_B00C);
		print_test_line("dirty eviction", errs_before);
	endtask

	task automatic random_traffic();
		int                       errs_before;
		logic [31:0]              bits;
		logic                     is_write;
		logic [`CACHE_ADDR_W-1:0] addr;
		word_t                    wdata;
		word_t                    rdata;
		errs_before = error_count;
		for (int n = 0; n < 200; n++) begin
			bits = lfsr_bits(1);
			is_write = bits[0];
			// 64 lines of four words, eight tags per index
			addr = 30'(lfsr_bits(8));
			wdata = '0;
			if (is_write) begin
				wdata = lfsr_bits(32);
			end
			cpu_access(is_write, addr, wdata, rdata);
			if (!is_write) begin
				compare_value("random read data", rdata, shadow_word(addr));
			end
		end
		print_test_line("random traffic", errs_before);
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------

	initial begin
		int reset_wait;
		proc_read_i  <= 1'b0;
		proc_write_i <= 1'b0;
		proc_addr_i  <= '0;
		proc_wdata_i <= '0;
		check_count = 0;
		error_count = 0;
		aborted = 1'b0;
		lfsr_state = 32'h2b7f_5c3a;
		reset_wait = 0;
		while (rst_n !== 1'b1 && reset_wait < 50) begin
			@(posedge clk);
			reset_wait++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was never released");
			error_count++;
			aborted = 1'b1;
		end
		@(posedge clk);
		idle_after_reset();
		read_miss_then_hit();
		write_hit_readback();
		dirty_eviction();
		random_traffic();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/tb_clkgen.sv
// testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int HALF_PERIOD  = 2,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset held low for the first cycles
	initial begin
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire
